//--- verilog/dvb_cfg_pkg.sv
`default_nettype none

package dvb_cfg_pkg;

	localparam int BUS_DATA_W = 32;
	localparam int BUS_STRB_W = BUS_DATA_W / 8;
	localparam int REG_ADDR_W = 4;
	localparam int BAUD_DIV_W = 16;

	typedef logic [BUS_DATA_W-1:0] bus_data_t; // host data word
	typedef logic [BUS_STRB_W-1:0] bus_strb_t; // one bit per byte lane
	typedef logic [REG_ADDR_W-1:0] reg_addr_t; // word address

	typedef logic [BAUD_DIV_W-1:0] baud_div_t; // symbol period in clk cycles

	// register map
	localparam reg_addr_t ADDR_CTRL = 4'd0; // bit0 tx_enable
	localparam reg_addr_t ADDR_BAUD = 4'd1; // symbol period
	localparam reg_addr_t ADDR_INV = 4'd2; // bit0 freq_inv
	localparam reg_addr_t ADDR_BYPASS = 4'd3; // bit0 scramble_bypass

	// upper half of the read word for an unmapped address
	localparam logic [15:0] READ_ERR_TAG = 16'hE000;

endpackage

`default_nettype wire

//--- verilog/dvb_stream_pkg.sv
`default_nettype none

package dvb_stream_pkg;

	typedef logic [7:0] ts_byte_t; // transport stream byte

	localparam ts_byte_t SYNC_BYTE = 8'h47;
	localparam ts_byte_t SYNC_BYTE_INV = 8'hB8; // marks first packet of a group

	localparam int TS_PKT_LEN = 188; // bytes per packet
	localparam int PKTS_PER_GROUP = 8; // randomizer period in packets

	// randomizer register, msb holds stage 1
	typedef logic [14:0] prbs_t;

	localparam prbs_t PRBS_INIT = 15'b100101010000000;

	typedef logic signed [15:0] sample_t; // I/Q sample

endpackage

`default_nettype wire

//--- verilog/dvb_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

module dvb_cfg_regs (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input dvb_cfg_pkg::bus_strb_t wstrb,
	input dvb_cfg_pkg::reg_addr_t waddr,
	input dvb_cfg_pkg::bus_data_t wdata,
	input logic ren,
	input dvb_cfg_pkg::reg_addr_t raddr,
	output dvb_cfg_pkg::bus_data_t rdata,
	output logic tx_enable,
	output dvb_cfg_pkg::baud_div_t baud_div,
	output logic freq_inv,
	output logic scramble_bypass
);

	dvb_cfg_pkg::reg_addr_t wr_addr; // latched write address
	dvb_cfg_pkg::bus_data_t wr_data;
	dvb_cfg_pkg::bus_strb_t wr_strb;
	logic wr_pend; // second write cycle
	dvb_cfg_pkg::bus_data_t wr_old; // current contents of target register
	dvb_cfg_pkg::bus_data_t wr_merged;

	// keep old bytes where the strobe is clear
	function automatic dvb_cfg_pkg::bus_data_t merge_bytes(
		input dvb_cfg_pkg::bus_data_t old_word,
		input dvb_cfg_pkg::bus_data_t new_word,
		input dvb_cfg_pkg::bus_strb_t strb
	);
		dvb_cfg_pkg::bus_data_t res;
		res = old_word;
		for (int b = 0; b < dvb_cfg_pkg::BUS_STRB_W; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_pend <= 1'b0;
			wr_addr <= '0;
			wr_data <= '0;
			wr_strb <= '0;
		end else begin
			wr_pend <= wen;
			if (wen) begin
				wr_addr <= waddr;
				wr_data <= wdata;
				wr_strb <= wstrb;
			end
		end
	end

	always_comb begin
		case (wr_addr)
			dvb_cfg_pkg::ADDR_CTRL: wr_old = {31'd0, tx_enable};
			dvb_cfg_pkg::ADDR_BAUD: wr_old = {16'd0, baud_div};
			dvb_cfg_pkg::ADDR_INV: wr_old = {31'd0, freq_inv};
			dvb_cfg_pkg::ADDR_BYPASS: wr_old = {31'd0, scramble_bypass};
			default: wr_old = '0;
		endcase
	end

	assign wr_merged = merge_bytes(wr_old, wr_data, wr_strb);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_enable <= 1'b0;
			baud_div <= '0;
			freq_inv <= 1'b0;
			scramble_bypass <= 1'b0;
		end else if (wr_pend) begin
			case (wr_addr)
				dvb_cfg_pkg::ADDR_CTRL: tx_enable <= wr_merged[0];
				dvb_cfg_pkg::ADDR_BAUD: baud_div <= wr_merged[15:0];
				dvb_cfg_pkg::ADDR_INV: freq_inv <= wr_merged[0];
				dvb_cfg_pkg::ADDR_BYPASS: scramble_bypass <= wr_merged[0];
				default: ; // unmapped, write dropped
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			case (raddr)
				dvb_cfg_pkg::ADDR_CTRL: rdata <= {31'd0, tx_enable};
				dvb_cfg_pkg::ADDR_BAUD: rdata <= {16'd0, baud_div};
				dvb_cfg_pkg::ADDR_INV: rdata <= {31'd0, freq_inv};
				dvb_cfg_pkg::ADDR_BYPASS: rdata <= {31'd0, scramble_bypass};
				default: rdata <= {dvb_cfg_pkg::READ_ERR_TAG, 12'd0, raddr};
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/ts_packet_source.sv
`timescale 1ns/100ps
`default_nettype none

module ts_packet_source (
	input logic clk,
	input logic rst_n,
	input logic tx_enable,
	input logic byte_req,
	output dvb_stream_pkg::ts_byte_t src_byte,
	output logic src_valid,
	output logic src_pkt_start
);

	logic [7:0] byte_idx; // position inside the packet
	dvb_stream_pkg::ts_byte_t pkt_num; // low bits of packet count
	logic last_byte;

	assign last_byte = (byte_idx == 8'(dvb_stream_pkg::TS_PKT_LEN - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_idx <= 8'd0;
			pkt_num <= 8'd0;
			src_valid <= 1'b0;
			src_pkt_start <= 1'b0;
		end else if (!tx_enable) begin
			// back to start of packet 0
			byte_idx <= 8'd0;
			pkt_num <= 8'd0;
			src_valid <= 1'b0;
			src_pkt_start <= 1'b0;
		end else begin
			src_valid <= byte_req;
			src_pkt_start <= byte_req && (byte_idx == 8'd0);
			if (byte_req) begin
				if (last_byte) begin
					byte_idx <= 8'd0;
					pkt_num <= pkt_num + 8'd1;
				end else begin
					byte_idx <= byte_idx + 8'd1;
				end
			end
		end
	end

	// payload byte k is packet number plus k
	always_ff @(posedge clk) begin
		if (byte_req) begin
			if (byte_idx == 8'd0)
				src_byte <= dvb_stream_pkg::SYNC_BYTE;
			else
				src_byte <= pkt_num + byte_idx;
		end
	end

endmodule

`default_nettype wire

//--- verilog/energy_dispersal.sv
`timescale 1ns/100ps
`default_nettype none

module energy_dispersal (
	input logic clk,
	input logic rst_n,
	input logic tx_enable,
	input logic scramble_bypass,
	input dvb_stream_pkg::ts_byte_t src_byte,
	input logic src_valid,
	input logic src_pkt_start,
	output dvb_stream_pkg::ts_byte_t rnd_byte,
	output logic rnd_valid
);

	logic [2:0] grp_cnt; // packet within group of eight
	dvb_stream_pkg::prbs_t prbs;
	dvb_stream_pkg::prbs_t prbs_next; // state after eight steps
	dvb_stream_pkg::prbs_t prbs_step;
	dvb_stream_pkg::ts_byte_t prbs_bits; // first bit generated lands in msb
	logic fb;
	logic group_first;

	assign group_first = src_pkt_start && (grp_cnt == 3'd0);

	// 1 + x^14 + x^15, eight steps per byte
	always_comb begin
		prbs_step = prbs;
		fb = 1'b0;
		prbs_bits = '0;
		for (int b = 7; b >= 0; b--) begin
			fb = prbs_step[1] ^ prbs_step[0]; // stages 14 and 15
			prbs_bits[b] = fb;
			prbs_step = {fb, prbs_step[14:1]};
		end
		prbs_next = prbs_step;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || !tx_enable) begin
			grp_cnt <= 3'd0;
			prbs <= dvb_stream_pkg::PRBS_INIT;
			rnd_valid <= 1'b0;
		end else begin
			rnd_valid <= src_valid;
			if (src_valid) begin
				if (group_first)
					prbs <= dvb_stream_pkg::PRBS_INIT; // reload at inverted sync
				else
					prbs <= prbs_next; // also runs over sync bytes 2 to 8
				if (src_pkt_start) begin
					if (grp_cnt == 3'(dvb_stream_pkg::PKTS_PER_GROUP - 1))
						grp_cnt <= 3'd0;
					else
						grp_cnt <= grp_cnt + 3'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (src_valid) begin
			if (scramble_bypass)
				rnd_byte <= src_byte;
			else if (group_first)
				rnd_byte <= dvb_stream_pkg::SYNC_BYTE_INV;
			else if (src_pkt_start)
				rnd_byte <= src_byte; // plain sync byte
			else
				rnd_byte <= src_byte ^ prbs_bits;
		end
	end

endmodule

`default_nettype wire

//--- verilog/qpsk_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module qpsk_mapper #(
	parameter dvb_stream_pkg::sample_t QPSK_AMP = 16'sd11585
) (
	input logic clk,
	input logic rst_n,
	input logic tx_enable,
	input dvb_cfg_pkg::baud_div_t baud_div,
	input logic freq_inv,
	input dvb_stream_pkg::ts_byte_t rnd_byte,
	input logic rnd_valid,
	output logic byte_req,
	output logic sym_valid,
	output dvb_stream_pkg::sample_t sym_i,
	output dvb_stream_pkg::sample_t sym_q
);

	localparam dvb_stream_pkg::sample_t NEG_AMP = -QPSK_AMP;

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} state_t;

	state_t state;
	dvb_cfg_pkg::baud_div_t baud_cnt;
	dvb_cfg_pkg::baud_div_t div_eff; // period clamped at 4
	logic [1:0] sym_cnt; // dibit within the byte
	dvb_stream_pkg::ts_byte_t shift;
	logic sym_tick;
	logic sym_pulse;
	dvb_stream_pkg::sample_t i_pt;
	dvb_stream_pkg::sample_t q_pt;

	assign div_eff = (baud_div < 16'd4) ? 16'd4 : baud_div;
	assign sym_tick = (state == ST_RUN) && (baud_cnt >= div_eff - 16'd1);
	assign i_pt = shift[7] ? NEG_AMP : QPSK_AMP; // first bit of the pair
	assign q_pt = shift[6] ? NEG_AMP : QPSK_AMP;

	always_ff @(posedge clk) begin
		if (!rst_n || !tx_enable) begin
			state <= ST_IDLE;
			baud_cnt <= '0;
			sym_cnt <= 2'd0;
			byte_req <= 1'b0;
			sym_pulse <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			sym_pulse <= sym_tick;
			case (state)
				ST_IDLE: begin
					state <= ST_RUN;
					byte_req <= 1'b1; // first byte right after enable
					baud_cnt <= '0;
					sym_cnt <= 2'd0;
				end
				ST_RUN: begin
					if (sym_tick) begin
						baud_cnt <= '0;
						sym_cnt <= sym_cnt + 2'd1;
						byte_req <= (sym_cnt == 2'd3); // with fourth symbol
					end else begin
						baud_cnt <= baud_cnt + 16'd1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rnd_valid)
			shift <= rnd_byte;
		else if (sym_tick)
			shift <= {shift[5:0], 2'b00};
		if (sym_tick) begin
			sym_i <= freq_inv ? q_pt : i_pt; // inversion swaps I and Q
			sym_q <= freq_inv ? i_pt : q_pt;
		end
	end

	// no stray pulse in the cycle transmit is switched off
	assign sym_valid = sym_pulse & tx_enable;

endmodule

`default_nettype wire

//--- verilog/dvb_mod_top.sv
`timescale 1ns/100ps
`default_nettype none

module dvb_mod_top #(
	parameter dvb_stream_pkg::sample_t QPSK_AMP = 16'sd11585
) (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input dvb_cfg_pkg::bus_strb_t wstrb,
	input dvb_cfg_pkg::reg_addr_t waddr,
	input dvb_cfg_pkg::bus_data_t wdata,
	input logic ren,
	input dvb_cfg_pkg::reg_addr_t raddr,
	output dvb_cfg_pkg::bus_data_t rdata,
	output logic sym_valid,
	output dvb_stream_pkg::sample_t sym_i,
	output dvb_stream_pkg::sample_t sym_q
);

	logic tx_enable;
	dvb_cfg_pkg::baud_div_t baud_div;
	logic freq_inv;
	logic scramble_bypass;
	logic byte_req;
	dvb_stream_pkg::ts_byte_t src_byte;
	logic src_valid;
	logic src_pkt_start;
	dvb_stream_pkg::ts_byte_t rnd_byte;
	logic rnd_valid;

	dvb_cfg_regs u_cfg_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.wstrb(wstrb),
		.waddr(waddr),
		.wdata(wdata),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.tx_enable(tx_enable),
		.baud_div(baud_div),
		.freq_inv(freq_inv),
		.scramble_bypass(scramble_bypass)
	);

	ts_packet_source u_source (
		.clk(clk),
		.rst_n(rst_n),
		.tx_enable(tx_enable),
		.byte_req(byte_req),
		.src_byte(src_byte),
		.src_valid(src_valid),
		.src_pkt_start(src_pkt_start)
	);

	energy_dispersal u_dispersal (
		.clk(clk),
		.rst_n(rst_n),
		.tx_enable(tx_enable),
		.scramble_bypass(scramble_bypass),
		.src_byte(src_byte),
		.src_valid(src_valid),
		.src_pkt_start(src_pkt_start),
		.rnd_byte(rnd_byte),
		.rnd_valid(rnd_valid)
	);

	qpsk_mapper #(
		.QPSK_AMP(QPSK_AMP)
	) u_mapper (
		.clk(clk),
		.rst_n(rst_n),
		.tx_enable(tx_enable),
		.baud_div(baud_div),
		.freq_inv(freq_inv),
		.rnd_byte(rnd_byte),
		.rnd_valid(rnd_valid),
		.byte_req(byte_req),
		.sym_valid(sym_valid),
		.sym_i(sym_i),
		.sym_q(sym_q)
	);

endmodule

`default_nettype wire

//--- sim/dvb_mod_sva.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dvb_mod_sva #(
	parameter dvb_stream_pkg::sample_t QPSK_AMP = 16'sd11585
) (
	input logic clk,
	input logic rst_n,
	input logic tx_enable,
	input logic sym_valid,
	input dvb_stream_pkg::sample_t sym_i,
	input dvb_stream_pkg::sample_t sym_q
);

	localparam dvb_stream_pkg::sample_t NEG_AMP = -QPSK_AMP;

	sym_spacing_a: assert property (@(posedge clk) disable iff (!rst_n)
		sym_valid |=> !sym_valid)
		else $error("sym_valid high in two consecutive cycles");

	sym_when_off_a: assert property (@(posedge clk) disable iff (!rst_n)
		!tx_enable |-> !sym_valid)
		else $error("sym_valid while transmit is off");

	// constellation points only
	sym_i_level_a: assert property (@(posedge clk) disable iff (!rst_n)
		sym_valid |-> (sym_i == QPSK_AMP || sym_i == NEG_AMP))
		else $error("sym_i is not a QPSK level");

	sym_q_level_a: assert property (@(posedge clk) disable iff (!rst_n)
		sym_valid |-> (sym_q == QPSK_AMP || sym_q == NEG_AMP))
		else $error("sym_q is not a QPSK level");

endmodule

bind dvb_mod_top tb_dvb_mod_sva #(
	.QPSK_AMP(QPSK_AMP)
) u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.tx_enable(tx_enable),
	.sym_valid(sym_valid),
	.sym_i(sym_i),
	.sym_q(sym_q)
);

`default_nettype wire

//--- sim/tb_dvb_mod.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dvb_mod;

	localparam dvb_stream_pkg::sample_t AMP = 16'sd11585;

	logic clk = 1'b0;
	logic rst_n;
	logic wen;
	dvb_cfg_pkg::bus_strb_t wstrb;
	dvb_cfg_pkg::reg_addr_t waddr;
	dvb_cfg_pkg::bus_data_t wdata;
	logic ren;
	dvb_cfg_pkg::reg_addr_t raddr;
	dvb_cfg_pkg::bus_data_t rdata;
	logic sym_valid;
	dvb_stream_pkg::sample_t sym_i;
	dvb_stream_pkg::sample_t sym_q;

	logic [15:0] lfsr = 16'd35;
	logic [1:15] ref_prbs; // stage 1 on the left
	logic [31:0] shadow [4]; // expected register fields

	dvb_mod_top #(
		.QPSK_AMP(AMP)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.wstrb(wstrb),
		.waddr(waddr),
		.wdata(wdata),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.sym_valid(sym_valid),
		.sym_i(sym_i),
		.sym_q(sym_q)
	);

	always #4 clk = ~clk;

	task automatic tick();
		@(posedge clk);
		#1; // drive and sample just after the edge
	endtask

	task automatic fail_run(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			fail_run("value mismatch");
		end
	endtask

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// eight steps of 1 + x^14 + x^15 with the first bit out in the msb
	function automatic logic [7:0] prbs_byte();
		logic [7:0] r;
		logic bit_out;
		r = '0;
		for (int i = 0; i < 8; i++) begin
			bit_out = ref_prbs[14] ^ ref_prbs[15];
			r = {r[6:0], bit_out};
			ref_prbs = {bit_out, ref_prbs[1:14]};
		end
		return r;
	endfunction

	// byte n of the stream after energy dispersal in stream order
	function automatic logic [7:0] ref_byte(input int n, input logic bypass);
		int pkt;
		int k;
		logic [7:0] plain;
		logic [7:0] mask;
		pkt = n / dvb_stream_pkg::TS_PKT_LEN;
		k = n % dvb_stream_pkg::TS_PKT_LEN;
		plain = (k == 0) ? dvb_stream_pkg::SYNC_BYTE : 8'(pkt + k);
		if (k == 0 && (pkt % dvb_stream_pkg::PKTS_PER_GROUP) == 0) begin
			ref_prbs = dvb_stream_pkg::PRBS_INIT; // group start
			return bypass ? plain : dvb_stream_pkg::SYNC_BYTE_INV;
		end
		mask = prbs_byte(); // also runs over plain sync bytes
		if (bypass || k == 0)
			return plain;
		return plain ^ mask;
	endfunction

	task automatic reg_write(input dvb_cfg_pkg::reg_addr_t addr,
		input dvb_cfg_pkg::bus_data_t data, input dvb_cfg_pkg::bus_strb_t strb);
		wen = 1'b1;
		waddr = addr;
		wdata = data;
		wstrb = strb;
		tick();
		wen = 1'b0;
		tick(); // register updated at this edge
	endtask

	task automatic reg_read(input dvb_cfg_pkg::reg_addr_t addr,
		output dvb_cfg_pkg::bus_data_t data);
		ren = 1'b1;
		raddr = addr;
		tick();
		ren = 1'b0;
		data = rdata;
	endtask

	task automatic wait_sym(input int limit, input string what, output int cycles);
		cycles = 0;
		do begin
			tick();
			cycles++;
		end while (!sym_valid && cycles < limit);
		if (!sym_valid)
			fail_run($sformatf("no sym_valid within %0d cycles (%s)", limit, what));
	endtask

	task automatic test_reset_state();
		dvb_cfg_pkg::bus_data_t rd;
		for (int a = 0; a < 4; a++) begin
			reg_read(4'(a), rd);
			check_val($sformatf("rdata at 0x%0h", a), rd, 32'd0);
		end
		repeat (40) begin
			tick();
			check_val("sym_valid", 32'(sym_valid), 32'd0); // transmit still off
		end
	endtask

	task automatic test_registers();
		logic [1:0] sel;
		dvb_cfg_pkg::bus_data_t data;
		dvb_cfg_pkg::bus_strb_t strb;
		dvb_cfg_pkg::bus_data_t rd;
		for (int n = 0; n < 16; n++) begin
			sel = 2'(rand_bits(2));
			data = rand_bits(32);
			strb = 4'(rand_bits(4));
			reg_write({2'b00, sel}, data, strb);
			for (int b = 0; b < 4; b++)
				if (strb[b])
					shadow[sel][8*b +: 8] = data[8*b +: 8];
			shadow[sel] &= (sel == 2'd1) ? 32'h0000FFFF : 32'h00000001; // field width
			reg_read({2'b00, sel}, rd);
			check_val($sformatf("rdata at 0x%0h", sel), rd, shadow[sel]);
		end
		for (int a = 4; a < 16; a++) begin
			reg_read(4'(a), rd);
			check_val($sformatf("rdata at 0x%0h", a), rd, {16'hE000, 12'd0, 4'(a)});
		end
		reg_write(dvb_cfg_pkg::ADDR_CTRL, 32'd0, 4'hF);
	endtask

	task automatic test_symbol_rate(input logic [15:0] div, input int period);
		int cycles;
		reg_write(dvb_cfg_pkg::ADDR_BAUD, {16'd0, div}, 4'hF);
		reg_write(dvb_cfg_pkg::ADDR_CTRL, 32'd1, 4'hF);
		wait_sym(period + 8, "first symbol", cycles);
		check_val("first sym_valid delay", cycles, period + 1); // one request cycle plus one period
		repeat (6) begin
			wait_sym(period + 8, "next symbol", cycles);
			check_val("sym_valid spacing", cycles, period);
		end
		reg_write(dvb_cfg_pkg::ADDR_CTRL, 32'd0, 4'hF);
	endtask

	task automatic test_stream(input int n_bytes, input logic bypass, input logic inv,
		input string what);
		int cycles;
		logic [7:0] exp_byte;
		logic [1:0] pair;
		dvb_stream_pkg::sample_t exp_i;
		dvb_stream_pkg::sample_t exp_q;
		reg_write(dvb_cfg_pkg::ADDR_BAUD, 32'd4, 4'hF);
		reg_write(dvb_cfg_pkg::ADDR_INV, {31'd0, inv}, 4'hF);
		reg_write(dvb_cfg_pkg::ADDR_BYPASS, {31'd0, bypass}, 4'hF);
		reg_write(dvb_cfg_pkg::ADDR_CTRL, 32'd1, 4'hF);
		for (int n = 0; n < n_bytes; n++) begin
			exp_byte = ref_byte(n, bypass);
			for (int s = 0; s < 4; s++) begin
				wait_sym(16, what, cycles);
				pair = 2'(exp_byte >> (6 - 2 * s)); // msb pair first
				exp_i = pair[1] ? -AMP : AMP;
				exp_q = pair[0] ? -AMP : AMP;
				check_val($sformatf("sym_i of %s byte %0d", what, n), 32'(sym_i),
					32'(inv ? exp_q : exp_i));
				check_val($sformatf("sym_q of %s byte %0d", what, n), 32'(sym_q),
					32'(inv ? exp_i : exp_q));
			end
		end
		reg_write(dvb_cfg_pkg::ADDR_CTRL, 32'd0, 4'hF);
	endtask

	initial begin
		rst_n = 1'b0;
		wen = 1'b0;
		wstrb = '0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		for (int a = 0; a < 4; a++)
			shadow[a] = 32'd0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_state();
		test_registers();
		test_symbol_rate(16'd6, 6);
		test_symbol_rate(16'd2, 4); // clamped to 4
		test_stream(2 * dvb_stream_pkg::TS_PKT_LEN, 1'b1, 1'b0, "bypass");
		test_stream(9 * dvb_stream_pkg::TS_PKT_LEN, 1'b0, 1'b0, "scrambled");
		test_stream(dvb_stream_pkg::TS_PKT_LEN, 1'b0, 1'b1, "freq_inv");
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
verilog/dvb_cfg_pkg.sv
verilog/dvb_stream_pkg.sv
verilog/dvb_cfg_regs.sv
verilog/ts_packet_source.sv
verilog/energy_dispersal.sv
verilog/qpsk_mapper.sv
verilog/dvb_mod_top.sv
sim/dvb_mod_sva.sv
sim/tb_dvb_mod.sv

//--- run_sim.sh
#!/bin/sh
# build and run the modulator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dvb_mod -f flist.f

# the simulator output goes to the terminal and to the log
./obj_dir/Vtb_dvb_mod 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"
